// ==== Bender.yml ====
package:
  name: tl_traffic

sources:
  - files:
      - design/tl_pkg.sv
      - design/tl_apb_regs.sv
      - design/tl_phase_seq.sv
      - design/tl_countdown.sv
      - design/tl_seg_scan.sv
      - design/tl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_tl_top.sv

// ==== design/tl_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_apb_regs
	import tl_pkg::*;
(
	input wire CLK_100Hz,
	input wire RSTN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [APB_ADDR_W-1:0] paddr,
	input wire [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic run,
	output logic [LEN_W-1:0] len1,
	output logic [LEN_W-1:0] len2,
	output logic [LEN_W-1:0] len3
);

	reg_addr_e addr;
	logic access;
	logic len_ok;
	logic err;

	assign addr = reg_addr_e'(paddr);
	assign access = psel && penable;
	assign len_ok = (pwdata >= APB_DATA_W'(LEN_MIN)) && (pwdata <= APB_DATA_W'(LEN_MAX));
	assign pready = 1'b1; // No wait states
	assign pslverr = access && err;

	always_comb
	begin
		prdata = '0;
		err = 1'b0;
		case (addr)
			REG_CTRL: prdata = APB_DATA_W'(run);
			REG_LEN1:
			begin
				prdata = APB_DATA_W'(len1);
				err = pwrite && !len_ok;
			end
			REG_LEN2:
			begin
				prdata = APB_DATA_W'(len2);
				err = pwrite && !len_ok;
			end
			REG_LEN3:
			begin
				prdata = APB_DATA_W'(len3);
				err = pwrite && !len_ok;
			end
			default: err = 1'b1; // Unmapped
		endcase
	end

	always_ff @(posedge CLK_100Hz)
	begin
		if (!RSTN)
		begin
			run <= 1'b0;
			len1 <= DEFAULT_LEN;
			len2 <= DEFAULT_LEN;
			len3 <= DEFAULT_LEN;
		end
		else if (access && pwrite && !err)
		begin
			case (addr)
				REG_CTRL: run <= pwdata[0];
				REG_LEN1: len1 <= pwdata[LEN_W-1:0];
				REG_LEN2: len2 <= pwdata[LEN_W-1:0];
				REG_LEN3: len3 <= pwdata[LEN_W-1:0];
				default: run <= run;
			endcase
		end
	end

	a_pready_high: assert property (@(posedge CLK_100Hz) disable iff (!RSTN) pready);

	a_err_in_access: assert property (@(posedge CLK_100Hz) disable iff (!RSTN)
		$rose(pslverr) |-> psel && penable);

endmodule

`default_nettype wire

// ==== design/tl_countdown.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_countdown
	import tl_pkg::*;
(
	input wire CLK_100Hz,
	input wire RSTN,
	input wire start,
	input wire [LEN_W-1:0] len_sec,
	input wire tick,
	input wire clear,
	output logic expire,
	output logic [DIGIT_W-1:0] sec_digit,
	output logic [DIGIT_W-1:0] tens_digit,
	output logic [DIGIT_W-1:0] ones_digit
);

	assign expire = tick && (sec_digit == '0) && (tens_digit == '0) && (ones_digit == '0);

	always_ff @(posedge CLK_100Hz)
	begin
		if (!RSTN)
		begin
			sec_digit <= '0;
			tens_digit <= '0;
			ones_digit <= '0;
		end
		else if (start)
		begin
			sec_digit <= DIGIT_W'(len_sec) - 1'b1; // Phase runs (len-1).99 down to 0.00
			tens_digit <= DIGIT_W'(CENTI_MAX / 10);
			ones_digit <= DIGIT_W'(CENTI_MAX % 10);
		end
		else if (clear)
		begin
			sec_digit <= '0;
			tens_digit <= '0;
			ones_digit <= '0;
		end
		else if (tick && !expire)
		begin
			if (ones_digit != '0)
				ones_digit <= ones_digit - 1'b1;
			else
			begin
				ones_digit <= DIGIT_W'(CENTI_MAX % 10); // Borrow from tens
				if (tens_digit != '0)
					tens_digit <= tens_digit - 1'b1;
				else
				begin
					tens_digit <= DIGIT_W'(CENTI_MAX / 10);
					sec_digit <= sec_digit - 1'b1;
				end
			end
		end
	end

	a_bcd_range: assert property (@(posedge CLK_100Hz) disable iff (!RSTN)
		(sec_digit <= 4'd9) && (tens_digit <= 4'd9) && (ones_digit <= 4'd9));

endmodule

`default_nettype wire

// ==== design/tl_phase_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_phase_seq
	import tl_pkg::*;
(
	input wire CLK_100Hz,
	input wire RSTN,
	input wire run,
	input wire [LEN_W-1:0] len1,
	input wire [LEN_W-1:0] len2,
	input wire [LEN_W-1:0] len3,
	input wire stop,
	input wire btn1,
	input wire btn2,
	input wire btn3,
	input wire expire,
	output logic start,
	output logic [LEN_W-1:0] len_sec,
	output logic tick,
	output logic clear,
	output logic l1_r,
	output logic l1_g,
	output logic l2_r,
	output logic l2_g,
	output logic l3_r,
	output logic l3_g
);

	phase_e ph;
	phase_e nxt;

	always_comb
	begin
		nxt = ph;
		start = 1'b0;
		if (!run)
			nxt = PH_IDLE;
		else if (!stop)
		begin
			start = 1'b1;
			if (ph == PH_IDLE)
				nxt = PH_1;
			else if (btn1)
				nxt = PH_1; // Buttons restart the named phase
			else if (btn2)
				nxt = PH_2;
			else if (btn3)
				nxt = PH_3;
			else if (expire)
			begin
				case (ph)
					PH_1: nxt = PH_2;
					PH_2: nxt = PH_3;
					default: nxt = PH_1;
				endcase
			end
			else
				start = 1'b0;
		end
	end

	always_comb
	begin
		case (nxt)
			PH_2: len_sec = len2;
			PH_3: len_sec = len3;
			default: len_sec = len1;
		endcase
	end

	assign tick = (ph != PH_IDLE) && !stop;
	assign clear = (ph == PH_IDLE);

	always_ff @(posedge CLK_100Hz)
	begin
		if (!RSTN)
		begin
			ph <= PH_IDLE;
			{l1_r, l1_g, l2_r, l2_g, l3_r, l3_g} <= 6'b11_11_11; // Lamp test
		end
		else
		begin
			ph <= nxt;
			case (nxt)
				PH_1: {l1_r, l1_g, l2_r, l2_g, l3_r, l3_g} <= 6'b10_01_10;
				PH_2: {l1_r, l1_g, l2_r, l2_g, l3_r, l3_g} <= 6'b10_10_01;
				PH_3: {l1_r, l1_g, l2_r, l2_g, l3_r, l3_g} <= 6'b01_10_10;
				default: {l1_r, l1_g, l2_r, l2_g, l3_r, l3_g} <= 6'b11_11_11;
			endcase
		end
	end

	a_one_green: assert property (@(posedge CLK_100Hz) disable iff (!RSTN)
		(ph != PH_IDLE) |-> $onehot0({l1_g, l2_g, l3_g}));

	a_no_start_in_stop: assert property (@(posedge CLK_100Hz) disable iff (!RSTN)
		stop |-> !start);

endmodule

`default_nettype wire

// ==== design/tl_pkg.sv ====
`default_nettype none

package tl_pkg;

	localparam int APB_ADDR_W = 4;
	localparam int APB_DATA_W = 8;
	localparam int LEN_W = 4;
	localparam int DIGIT_W = 4;
	localparam int SEG_W = 8;
	localparam int COM_W = 4;

	localparam logic [LEN_W-1:0] LEN_MIN = 4'd1;
	localparam logic [LEN_W-1:0] LEN_MAX = 4'd9;
	localparam logic [LEN_W-1:0] DEFAULT_LEN = 4'd5;
	localparam int CENTI_MAX = 99; // Hundredths reload
	localparam logic [SEG_W-1:0] SEG_ZERO = 8'b1111_1100; // Segments a to f lit

	typedef enum logic [1:0]
	{
		PH_IDLE = 2'd0,
		PH_1    = 2'd1,
		PH_2    = 2'd2,
		PH_3    = 2'd3
	} phase_e;

	typedef enum logic [APB_ADDR_W-1:0]
	{
		REG_CTRL = 4'h0,
		REG_LEN1 = 4'h4,
		REG_LEN2 = 4'h8,
		REG_LEN3 = 4'hC
	} reg_addr_e;

	// Pattern is a..g from the MSB down, decimal point in bit 0
	function automatic logic [SEG_W-1:0] seg_encode(input logic [DIGIT_W-1:0] digit,
		input logic dp);
		logic [SEG_W-2:0] abcdefg;
		case (digit)
			4'd0: abcdefg = 7'b1111110;
			4'd1: abcdefg = 7'b0110000;
			4'd2: abcdefg = 7'b1101101;
			4'd3: abcdefg = 7'b1111001;
			4'd4: abcdefg = 7'b0110011;
			4'd5: abcdefg = 7'b1011011;
			4'd6: abcdefg = 7'b1011111;
			4'd7: abcdefg = 7'b1110000;
			4'd8: abcdefg = 7'b1111111;
			4'd9: abcdefg = 7'b1111011;
			default: abcdefg = 7'b0000001; // Dash on a non-BCD code
		endcase
		return {abcdefg, dp};
	endfunction

endpackage

`default_nettype wire

// ==== design/tl_seg_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_seg_scan
	import tl_pkg::*;
(
	input wire CLK_100Hz,
	input wire RSTN,
	input wire [DIGIT_W-1:0] sec_digit,
	input wire [DIGIT_W-1:0] tens_digit,
	input wire [DIGIT_W-1:0] ones_digit,
	output logic [COM_W-1:0] seg_com,
	output logic [SEG_W-1:0] seg_data
);

	logic [1:0] scan;

	// Common anode, so the selected digit is driven low
	always_ff @(posedge CLK_100Hz)
	begin
		if (!RSTN)
		begin
			scan <= 2'd0;
			seg_com <= '1;
			seg_data <= '0;
		end
		else
		begin
			scan <= scan + 1'b1;
			case (scan)
				2'd0:
				begin
					seg_com <= 4'b0111;
					seg_data <= SEG_ZERO; // Tens of seconds never used
				end
				2'd1:
				begin
					seg_com <= 4'b1011;
					seg_data <= seg_encode(sec_digit, 1'b1);
				end
				2'd2:
				begin
					seg_com <= 4'b1101;
					seg_data <= seg_encode(tens_digit, 1'b0);
				end
				default:
				begin
					seg_com <= 4'b1110;
					seg_data <= seg_encode(ones_digit, 1'b0);
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/tl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tl_top
	import tl_pkg::*;
(
	input wire CLK_100Hz,
	input wire RSTN,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire [APB_ADDR_W-1:0] paddr,
	input wire [APB_DATA_W-1:0] pwdata,
	output logic [APB_DATA_W-1:0] prdata,
	output logic pready,
	output logic pslverr,
	input wire stop,
	input wire btn1,
	input wire btn2,
	input wire btn3,
	output logic l1_r,
	output logic l1_g,
	output logic l2_r,
	output logic l2_g,
	output logic l3_r,
	output logic l3_g,
	output logic [COM_W-1:0] seg_com,
	output logic [SEG_W-1:0] seg_data
);

	logic run;
	logic [LEN_W-1:0] len1;
	logic [LEN_W-1:0] len2;
	logic [LEN_W-1:0] len3;
	logic start;
	logic [LEN_W-1:0] len_sec;
	logic tick;
	logic clear;
	logic expire;
	logic [DIGIT_W-1:0] sec_digit;
	logic [DIGIT_W-1:0] tens_digit;
	logic [DIGIT_W-1:0] ones_digit;

	tl_apb_regs u_regs (
		.CLK_100Hz(CLK_100Hz), .RSTN(RSTN),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.run(run), .len1(len1), .len2(len2), .len3(len3)
	);

	tl_phase_seq u_seq (
		.CLK_100Hz(CLK_100Hz), .RSTN(RSTN),
		.run(run), .len1(len1), .len2(len2), .len3(len3),
		.stop(stop), .btn1(btn1), .btn2(btn2), .btn3(btn3),
		.expire(expire),
		.start(start), .len_sec(len_sec), .tick(tick), .clear(clear),
		.l1_r(l1_r), .l1_g(l1_g), .l2_r(l2_r), .l2_g(l2_g),
		.l3_r(l3_r), .l3_g(l3_g)
	);

	tl_countdown u_cnt (
		.CLK_100Hz(CLK_100Hz), .RSTN(RSTN),
		.start(start), .len_sec(len_sec), .tick(tick), .clear(clear),
		.expire(expire),
		.sec_digit(sec_digit), .tens_digit(tens_digit), .ones_digit(ones_digit)
	);

	tl_seg_scan u_scan (
		.CLK_100Hz(CLK_100Hz), .RSTN(RSTN),
		.sec_digit(sec_digit), .tens_digit(tens_digit), .ones_digit(ones_digit),
		.seg_com(seg_com), .seg_data(seg_data)
	);

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
(
	output logic CLK_100Hz,
	output logic RSTN
);

	initial
	begin
		CLK_100Hz = 1'b0;
		forever #20 CLK_100Hz = ~CLK_100Hz; // 40 ns period
	end

	initial
	begin
		RSTN = 1'b0;
		repeat (4) @(posedge CLK_100Hz);
		#1 RSTN = 1'b1; // Released just after the fourth edge
	end

endmodule

`default_nettype wire

// ==== include/tl_tb_table.svh ====
`ifndef TL_TB_TABLE_SVH
`define TL_TB_TABLE_SVH

// Columns: operation, address or button, write data or cycles, pslverr, read data or lamps
// Lamps are packed as {l1_r, l1_g, l2_r, l2_g, l3_r, l3_g}
typedef enum int
{
	OP_WR,     // APB write
	OP_RD,     // APB read
	OP_RUN,    // Run N cycles, then lamps
	OP_FREEZE, // Stop at a random offset for N cycles
	OP_BTN     // One-cycle button press, then lamps
} op_e;

localparam int LAMPS_PH1 = 6'b100110;
localparam int LAMPS_PH2 = 6'b101001;
localparam int LAMPS_PH3 = 6'b011010;
localparam int LAMPS_IDLE = 6'b111111;

op_e row_op[$];
logic [3:0] row_addr[$];
int row_data[$];
logic row_err[$];
int row_val[$];

task automatic add_row(input op_e op, input logic [3:0] addr, input int data,
	input logic err, input int val);
	row_op.push_back(op);
	row_addr.push_back(addr);
	row_data.push_back(data);
	row_err.push_back(err);
	row_val.push_back(val);
endtask

task automatic build_table;
	add_row(OP_RD, REG_CTRL, 0, 1'b0, 0); // Reset values
	add_row(OP_RD, REG_LEN1, 0, 1'b0, 5);
	add_row(OP_RD, REG_LEN3, 0, 1'b0, 5);
	add_row(OP_WR, REG_LEN2, 0, 1'b1, 0); // Out of range
	add_row(OP_WR, REG_LEN3, 10, 1'b1, 0);
	add_row(OP_WR, 4'h2, 7, 1'b1, 0); // Unmapped
	add_row(OP_RD, 4'h2, 0, 1'b1, 0);
	add_row(OP_RD, REG_LEN2, 0, 1'b0, 5);
	add_row(OP_RD, REG_LEN3, 0, 1'b0, 5);
	add_row(OP_WR, REG_LEN1, 1, 1'b0, 0);
	add_row(OP_WR, REG_LEN2, 2, 1'b0, 0);
	add_row(OP_WR, REG_LEN3, 1, 1'b0, 0);
	add_row(OP_RD, REG_LEN1, 0, 1'b0, 1);
	add_row(OP_RD, REG_LEN2, 0, 1'b0, 2);
	add_row(OP_RD, REG_LEN3, 0, 1'b0, 1);
	add_row(OP_WR, REG_CTRL, 1, 1'b0, 0);
	add_row(OP_RUN, 4'h0, 1, 1'b0, LAMPS_PH1); // Entry one edge after the write
	add_row(OP_RUN, 4'h0, 99, 1'b0, LAMPS_PH1);
	add_row(OP_RUN, 4'h0, 1, 1'b0, LAMPS_PH2);
	add_row(OP_RUN, 4'h0, 199, 1'b0, LAMPS_PH2);
	add_row(OP_RUN, 4'h0, 1, 1'b0, LAMPS_PH3);
	add_row(OP_RUN, 4'h0, 99, 1'b0, LAMPS_PH3);
	add_row(OP_RUN, 4'h0, 1, 1'b0, LAMPS_PH1);
	add_row(OP_RUN, 4'h0, 37, 1'b0, LAMPS_PH1);
	add_row(OP_FREEZE, 4'h0, 300, 1'b0, 0);
	add_row(OP_FREEZE, 4'h0, 300, 1'b0, 0);
	add_row(OP_WR, REG_LEN3, 4, 1'b0, 0);
	add_row(OP_BTN, 4'd3, 0, 1'b0, LAMPS_PH3); // Restart of PH_3
	add_row(OP_RUN, 4'h0, 8, 1'b0, LAMPS_PH3);
	add_row(OP_RD, REG_CTRL, 0, 1'b0, 1);
	add_row(OP_WR, REG_CTRL, 0, 1'b0, 0);
	add_row(OP_RUN, 4'h0, 2, 1'b0, LAMPS_IDLE);
	add_row(OP_RUN, 4'h0, 8, 1'b0, LAMPS_IDLE);
endtask

`endif

// ==== tb/tb_tl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tl_top
	import tl_pkg::*;
();

	wire CLK_100Hz;
	wire RSTN;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [APB_DATA_W-1:0] pwdata;
	logic stop;
	logic btn1;
	logic btn2;
	logic btn3;
	wire [APB_DATA_W-1:0] prdata;
	wire pready;
	wire pslverr;
	wire l1_r;
	wire l1_g;
	wire l2_r;
	wire l2_g;
	wire l3_r;
	wire l3_g;
	wire [COM_W-1:0] seg_com;
	wire [SEG_W-1:0] seg_data;
	logic [5:0] lamps;
	int ncyc;
	int limit;
	logic [15:0] lfsr;
	logic m_run;
	int m_len [1:3];
	int m_ph; // 0 is idle
	int m_rem; // Hundredths left in the phase
	int m_scan;
	logic [COM_W-1:0] e_com;
	logic [SEG_W-1:0] e_data;

	`include "tl_tb_table.svh"

	tb_clock_gen u_clk (.CLK_100Hz(CLK_100Hz), .RSTN(RSTN));

	tl_top u_tl_top (.*);

	assign lamps = {l1_r, l1_g, l2_r, l2_g, l3_r, l3_g};

	task automatic fail_stop;
		$display("Something failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [31:0] act, input logic [31:0] exp, input string what);
		if (act !== exp)
		begin
			$display("CHECK FAILED at %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, act, exp);
			fail_stop();
		end
	endtask

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		repeat (n)
		begin
			v = (v << 1) | lfsr[0];
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// a..g from the MSB down, decimal point in bit 0
	function automatic logic [7:0] seg_pattern(input int digit, input bit dp);
		logic [7:0] p;
		case (digit)
			0: p = 8'hFC;
			1: p = 8'h60;
			2: p = 8'hDA;
			3: p = 8'hF2;
			4: p = 8'h66;
			5: p = 8'hB6;
			6: p = 8'hBE;
			7: p = 8'hE0;
			8: p = 8'hFE;
			default: p = 8'hF6;
		endcase
		return p | {7'b0, dp};
	endfunction

	function automatic logic [5:0] lamp_pattern(input int ph);
		case (ph)
			1: return LAMPS_PH1;
			2: return LAMPS_PH2;
			3: return LAMPS_PH3;
			default: return LAMPS_IDLE;
		endcase
	endfunction

	// One clock edge of the reference model, using the inputs the DUT saw
	task automatic model_step;
		bit tk;
		bit ex;
		bit st;
		int nph;
		e_com = ~(4'b1000 >> m_scan);
		if (m_scan == 0)
			e_data = seg_pattern(0, 1'b0);
		else if (m_scan == 1)
			e_data = seg_pattern(m_rem / 100, 1'b1);
		else if (m_scan == 2)
			e_data = seg_pattern((m_rem / 10) % 10, 1'b0);
		else
			e_data = seg_pattern(m_rem % 10, 1'b0);
		m_scan = (m_scan + 1) % 4;
		tk = (m_ph != 0) && !stop;
		ex = tk && (m_rem == 0);
		// Entry from idle, by a button or when the countdown runs out
		st = m_run && !stop && (m_ph == 0 || btn1 || btn2 || btn3 || ex);
		if (!m_run)
			nph = 0;
		else if (!st)
			nph = m_ph;
		else if (m_ph == 0 || btn1)
			nph = 1;
		else if (btn2)
			nph = 2;
		else if (btn3)
			nph = 3;
		else
			nph = m_ph % 3 + 1;
		if (st)
			m_rem = m_len[nph] * 100 - 1;
		else if (m_ph == 0)
			m_rem = 0;
		else if (tk && m_rem > 0)
			m_rem--;
		m_ph = nph;
		if (psel && penable && pwrite)
		begin
			if (paddr == 4'h0)
				m_run = pwdata[0];
			else if ((paddr == 4'h4 || paddr == 4'h8 || paddr == 4'hC) && pwdata >= 1 && pwdata <= 9)
				m_len[paddr / 4] = pwdata;
		end
	endtask

	task automatic next_cycle;
		@(posedge CLK_100Hz);
		model_step();
		#2;
		ncyc++;
		if (ncyc > limit)
		begin
			$display("Timeout: the table did not finish within %0d cycles", limit);
			fail_stop();
		end
		check_value(lamps, lamp_pattern(m_ph), "lamps");
		check_value(seg_com, e_com, "seg_com");
		check_value(seg_data, e_data, "seg_data");
	endtask

	task automatic apb_access(input logic wr, input logic [3:0] a, input logic [7:0] d,
		output logic [7:0] rd, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = a;
		pwdata = d;
		next_cycle();
		penable = 1'b1;
		#1;
		rd = prdata;
		err = pslverr;
		check_value(pready, 1'b1, "pready");
		next_cycle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	function automatic int row_cycles(input int i);
		case (row_op[i])
			OP_WR, OP_RD: return 2;
			OP_RUN: return row_data[i];
			OP_FREEZE: return 40 + row_data[i]; // Offset of at most 32, then 8
			default: return 1;
		endcase
	endfunction

	initial
	begin
		logic [7:0] rd;
		logic err;
		int off;
		int waited;
		logic [5:0] held;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		stop = 1'b0;
		btn1 = 1'b0;
		btn2 = 1'b0;
		btn3 = 1'b0;
		m_run = 1'b0;
		m_len = '{5, 5, 5};
		m_ph = 0;
		m_rem = 0;
		m_scan = 0;
		e_com = '1;
		e_data = '0;
		ncyc = 0;
		waited = 0;
		lfsr = 16'd38981;
		build_table();
		limit = 200;
		for (int i = 0; i < row_op.size(); i++)
			limit += row_cycles(i);
		while (RSTN !== 1'b1)
		begin
			@(posedge CLK_100Hz);
			#2;
			waited++;
			if (waited > 10)
			begin
				$display("Reset was never released");
				fail_stop();
			end
		end
		check_value(lamps, LAMPS_IDLE, "lamps after reset");
		check_value(seg_com, e_com, "seg_com after reset");
		check_value(seg_data, e_data, "seg_data after reset");
		for (int i = 0; i < row_op.size(); i++)
		begin
			case (row_op[i])
				OP_WR, OP_RD:
				begin
					apb_access(row_op[i] == OP_WR, row_addr[i], 8'(row_data[i]), rd, err);
					check_value(err, row_err[i], "pslverr");
					if (row_op[i] == OP_RD)
						check_value(rd, row_val[i], "prdata");
				end
				OP_RUN:
				begin
					repeat (row_data[i]) next_cycle();
					check_value(lamps, row_val[i], "lamps after run");
				end
				OP_FREEZE:
				begin
					take_bits(5, off);
					repeat (off + 1) next_cycle();
					stop = 1'b1;
					repeat (8) next_cycle();
					held = lamps;
					repeat (row_data[i]) next_cycle(); // Scan keeps going on frozen digits
					check_value(lamps, held, "lamps during stop");
					stop = 1'b0;
				end
				default:
				begin
					btn1 = (row_addr[i] == 4'd1);
					btn2 = (row_addr[i] == 4'd2);
					btn3 = (row_addr[i] == 4'd3);
					next_cycle();
					btn1 = 1'b0;
					btn2 = 1'b0;
					btn3 = 1'b0;
					check_value(lamps, row_val[i], "lamps after button");
				end
			endcase
		end
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+include
design/tl_pkg.sv
design/tl_apb_regs.sv
design/tl_phase_seq.sv
design/tl_countdown.sv
design/tl_seg_scan.sv
design/tl_top.sv
tb/tb_clock_gen.sv
tb/tb_tl_top.sv
